/* ulpi_pkg.sv */
package ulpi_pkg;

  // Line-state timer limits, in ulpi_clk cycles at 60 MHz
  localparam int RESET_TIME   = 190000;  // ~3 ms of SE0
  localparam int SUSPEND_TIME = 190000;  // ~3 ms of J
  localparam int SWITCH_TIME  = 6000;    // ~100 us settle

  localparam int TIMER_W = 18;

  // Register write commands (0x80 | address)
  localparam logic [7:0] REG_WRITE_OTG_CTRL  = 8'h8A;
  localparam logic [7:0] REG_WRITE_FUNC_CTRL = 8'h84;

  localparam logic [7:0] OTG_CTRL_INIT = 8'h00;  // No pulldowns, no VBUS drive
  // SuspendM=1, OpMode normal, TermSelect=1, XcvrSelect=FS
  localparam logic [7:0] FUNC_CTRL_FS  = 8'b0_1_0_00_1_01;

  localparam logic [3:0] TX_CMD_PREFIX = 4'b0100;  // Transmit, PID in low nibble

  localparam logic [1:0] LINE_SE0 = 2'b00;
  localparam logic [1:0] LINE_J   = 2'b01;

  localparam logic [1:0] RX_ACTIVE_CODE = 2'b01;

  typedef enum logic [3:0] {
    ST_INIT            = 4'h0,
    ST_WRITE_REGA      = 4'h1,
    ST_WRITE_REGD      = 4'h2,
    ST_STP             = 4'h3,
    ST_SWITCH_FS_START = 4'h4,
    ST_SWITCH_FS       = 4'h5,
    ST_IDLE            = 4'h6,
    ST_TX              = 4'h7,
    ST_TX_LAST         = 4'h8,
    ST_RESET           = 4'h9,
    ST_SUSPEND         = 4'hA
  } link_state_e;

  // RX CMD byte as sent by the PHY
  typedef struct packed {
    logic [1:0] alt_int;
    logic [1:0] rx_event;
    logic [1:0] vbus_state;
    logic [1:0] line_state;
  } rx_cmd_t;

  // Same byte is packet data or an RX CMD, depending on nxt
  typedef union packed {
    logic [7:0] raw;
    rx_cmd_t    cmd;
  } ulpi_byte_u;

  typedef struct packed {
    logic dir_q;
    logic rx_cmd;     // PHY drives, nxt low
    logic rx_data;    // PHY drives, nxt high
    logic link_owns;  // dir low now and last cycle
  } bus_phase_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_beat_t;

  typedef struct packed {
    logic [1:0] line_state;
    logic       vbus_valid;
    logic       reset_seen;
    logic       suspend_seen;
  } line_status_t;

endpackage

/* ulpi_line_monitor.sv */
`timescale 1ns/1ps

module ulpi_line_monitor import ulpi_pkg::*; (
  input  logic         ulpi_clk,
  input  logic         rst_n,
  input  ulpi_byte_u   ulpi_data_i,
  input  logic         ulpi_dir_i,
  input  logic         ulpi_nxt_i,
  input  logic         timer_clr_i,
  output bus_phase_t   phase_o,
  output line_status_t status_o
);

  logic               dir_q;
  logic [1:0]         line_q;
  logic               vbus_q;
  logic [TIMER_W-1:0] timer_q;
  logic               line_change;

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      dir_q <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
    end
  end

  // Turnaround cycles fall in none of the three classes
  assign phase_o.dir_q     = dir_q;
  assign phase_o.rx_cmd    = dir_q && ulpi_dir_i && !ulpi_nxt_i;
  assign phase_o.rx_data   = dir_q && ulpi_dir_i && ulpi_nxt_i;
  assign phase_o.link_owns = !dir_q && !ulpi_dir_i;

  assign line_change = phase_o.rx_cmd && (ulpi_data_i.cmd.line_state != line_q);

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      line_q <= LINE_SE0;
      vbus_q <= 1'b0;
    end else if (phase_o.rx_cmd) begin
      line_q <= ulpi_data_i.cmd.line_state;
      vbus_q <= ulpi_data_i.cmd.vbus_state == 2'b11;  // Only VbusValid counts
    end
  end

  // Time since the last line-state change
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else if (line_change || timer_clr_i) begin
      timer_q <= '0;
    end else if (timer_q != '1) begin
      timer_q <= timer_q + 1'b1;  // Saturates so a long state stays seen
    end
  end

  assign status_o.line_state   = line_q;
  assign status_o.vbus_valid   = vbus_q;
  assign status_o.reset_seen   = (line_q == LINE_SE0) && (timer_q > TIMER_W'(RESET_TIME));
  assign status_o.suspend_seen = (line_q == LINE_J) && (timer_q > TIMER_W'(SUSPEND_TIME));

  // A long line state is only reported while the line stands still
  long_state_stable_a: assert property (
    @(posedge ulpi_clk) disable iff (!rst_n)
    (status_o.reset_seen || status_o.suspend_seen) |-> $stable(line_q)
  );

endmodule

/* ulpi_rx_path.sv */
`timescale 1ns/1ps

module ulpi_rx_path import ulpi_pkg::*; (
  input  logic         ulpi_clk,
  input  logic         rst_n,
  input  ulpi_byte_u   ulpi_data_i,
  input  logic         ulpi_dir_i,
  input  bus_phase_t   phase_i,
  input  logic         rx_ready_i,
  output logic         rx_valid_o,
  output stream_beat_t rx_beat_o,
  output logic         rx_overflow_o
);

  logic       in_pkt_q;   // Hold register has a byte
  logic [7:0] hold_q;
  logic [7:0] out_data_q;
  logic       out_last_q;
  logic       pkt_end;

  // End of packet: RxActive dropped in an RX CMD, or PHY released the bus
  assign pkt_end = in_pkt_q &&
                   ((phase_i.rx_cmd && ulpi_data_i.cmd.rx_event != RX_ACTIVE_CODE) ||
                    (phase_i.dir_q && !ulpi_dir_i));

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      in_pkt_q   <= 1'b0;
      rx_valid_o <= 1'b0;
      out_last_q <= 1'b0;
    end else if (phase_i.rx_data) begin
      in_pkt_q   <= 1'b1;
      rx_valid_o <= in_pkt_q;  // First byte only fills the hold register
      out_last_q <= 1'b0;
    end else if (pkt_end) begin
      in_pkt_q   <= 1'b0;
      rx_valid_o <= 1'b1;
      out_last_q <= 1'b1;
    end else begin
      rx_valid_o <= 1'b0;
      out_last_q <= 1'b0;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (phase_i.rx_data) begin
      hold_q <= ulpi_data_i.raw;
    end
    if ((phase_i.rx_data && in_pkt_q) || pkt_end) begin
      out_data_q <= hold_q;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      rx_overflow_o <= 1'b0;
    end else if (rx_valid_o && !rx_ready_i) begin
      rx_overflow_o <= 1'b1;  // Sticky until reset
    end
  end

  assign rx_beat_o.data = out_data_q;
  assign rx_beat_o.last = out_last_q;

  // Hold register is empty after the last beat
  quiet_after_last_a: assert property (
    @(posedge ulpi_clk) disable iff (!rst_n)
    (rx_valid_o && rx_beat_o.last) |=> !rx_valid_o
  );

endmodule

/* ulpi_link_fsm.sv */
`timescale 1ns/1ps

module ulpi_link_fsm import ulpi_pkg::*; (
  input  logic         ulpi_clk,
  input  logic         rst_n,
  input  logic         ulpi_dir_i,
  input  logic         ulpi_nxt_i,
  input  bus_phase_t   phase_i,
  input  line_status_t status_i,
  input  logic         tx_valid_i,
  input  stream_beat_t tx_beat_i,
  input  logic         rx_ready_i,
  output logic [7:0]   ulpi_data_o,
  output logic         ulpi_stp_o,
  output logic         tx_ready_o,
  output logic         timer_clr_o,
  output logic         usb_reset_o,
  output logic         usb_idle_o,
  output logic         usb_suspend_o
);

  link_state_e        state_q;
  link_state_e        ret_q;       // State after a register write
  logic [7:0]         reg_data_q;
  stream_beat_t       buf_q;
  logic               buf_valid_q;
  logic               buf_load;
  logic [TIMER_W-1:0] settle_q;
  logic [1:0]         line_q;
  logic               line_moved;

  assign timer_clr_o   = state_q == ST_SWITCH_FS_START;
  assign usb_idle_o    = state_q == ST_IDLE;
  assign usb_suspend_o = state_q == ST_SUSPEND;

  assign line_moved = status_i.line_state != line_q;

  // Catch the beat that arrives while the PHY stalls
  assign buf_load = phase_i.link_owns && state_q == ST_TX && !ulpi_nxt_i &&
                    tx_valid_i && tx_ready_o && !buf_valid_q;

  // Settle time after the switch to full speed, restarted on line changes
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      settle_q <= '0;
      line_q   <= LINE_SE0;
    end else begin
      line_q <= status_i.line_state;
      if (state_q != ST_SWITCH_FS || line_moved) begin
        settle_q <= '0;
      end else if (settle_q != '1) begin
        settle_q <= settle_q + 1'b1;
      end
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      state_q     <= ST_INIT;
      ret_q       <= ST_INIT;
      ulpi_data_o <= 8'h00;
    end else if (phase_i.link_owns) begin
      case (state_q)
        ST_INIT: begin
          state_q     <= ST_WRITE_REGA;
          ret_q       <= ST_SWITCH_FS_START;
          ulpi_data_o <= REG_WRITE_OTG_CTRL;
          reg_data_q  <= OTG_CTRL_INIT;
        end
        ST_SWITCH_FS_START: begin
          state_q     <= ST_WRITE_REGA;
          ret_q       <= ST_SWITCH_FS;
          ulpi_data_o <= REG_WRITE_FUNC_CTRL;
          reg_data_q  <= FUNC_CTRL_FS;
        end
        ST_WRITE_REGA: begin
          if (ulpi_nxt_i) begin  // Command taken, data next
            state_q     <= ST_WRITE_REGD;
            ulpi_data_o <= reg_data_q;
          end
        end
        ST_WRITE_REGD: begin
          if (ulpi_nxt_i) begin
            state_q     <= ST_STP;
            ulpi_data_o <= 8'h00;
          end
        end
        ST_STP: begin
          state_q <= ret_q;
        end
        ST_SWITCH_FS: begin
          if (settle_q >= TIMER_W'(SWITCH_TIME - 1)) begin
            state_q <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (status_i.reset_seen) begin
            state_q <= ST_RESET;
          end else if (status_i.suspend_seen) begin
            state_q <= ST_SUSPEND;
          end else if (tx_valid_i) begin
            ulpi_data_o <= {TX_CMD_PREFIX, tx_beat_i.data[3:0]};  // PID as TX CMD
            state_q     <= tx_beat_i.last ? ST_TX_LAST : ST_TX;
          end
        end
        ST_TX: begin
          if (ulpi_nxt_i) begin
            if (buf_valid_q) begin
              ulpi_data_o <= buf_q.data;
              state_q     <= buf_q.last ? ST_TX_LAST : ST_TX;
            end else if (tx_valid_i) begin
              ulpi_data_o <= tx_beat_i.data;
              state_q     <= tx_beat_i.last ? ST_TX_LAST : ST_TX;
            end else begin
              ulpi_data_o <= 8'h00;  // Source ran dry
            end
          end
        end
        ST_TX_LAST: begin
          if (ulpi_nxt_i) begin
            state_q     <= ST_STP;
            ret_q       <= ST_IDLE;
            ulpi_data_o <= 8'h00;
          end
        end
        ST_RESET: begin
          if (status_i.line_state != LINE_SE0) begin
            state_q <= ST_IDLE;
          end
        end
        ST_SUSPEND: begin
          if (status_i.line_state != LINE_J) begin
            state_q <= ST_IDLE;  // Resume on K or SE0
          end
        end
        default: begin
          state_q     <= ST_INIT;
          ulpi_data_o <= 8'h00;
        end
      endcase
    end
  end

  // TX flow control and hold buffer
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n || !phase_i.link_owns) begin
      buf_valid_q <= 1'b0;
      tx_ready_o  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          buf_valid_q <= 1'b0;
          tx_ready_o  <= !(status_i.reset_seen || status_i.suspend_seen) &&
                         !(tx_valid_i && tx_beat_i.last);
        end
        ST_TX: begin
          if (ulpi_nxt_i) begin
            buf_valid_q <= 1'b0;
            if (buf_valid_q) begin
              tx_ready_o <= !buf_q.last;
            end else begin
              tx_ready_o <= tx_valid_i && !tx_beat_i.last;
            end
          end else begin
            if (buf_load) begin
              buf_valid_q <= 1'b1;
            end
            tx_ready_o <= 1'b0;
          end
        end
        default: begin
          buf_valid_q <= 1'b0;
          tx_ready_o  <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (buf_load) begin
      buf_q <= tx_beat_i;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      ulpi_stp_o <= 1'b0;
    end else if (phase_i.link_owns) begin
      ulpi_stp_o <= (state_q == ST_WRITE_REGD || state_q == ST_TX_LAST) && ulpi_nxt_i;
    end else begin
      ulpi_stp_o <= phase_i.dir_q && ulpi_dir_i && !rx_ready_i;  // Abort RX
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      usb_reset_o <= 1'b0;
    end else if (phase_i.link_owns) begin
      if (state_q == ST_RESET) begin
        usb_reset_o <= 1'b1;
      end else if (state_q == ST_IDLE) begin
        usb_reset_o <= 1'b0;
      end
    end
  end

  idle_data_zero_a: assert property (
    @(posedge ulpi_clk) disable iff (!rst_n)
    (state_q == ST_IDLE) |-> (ulpi_data_o == 8'h00)
  );

  stp_single_cycle_a: assert property (
    @(posedge ulpi_clk) disable iff (!rst_n)
    (phase_i.link_owns && ulpi_stp_o) |=> !ulpi_stp_o
  );

endmodule

/* usb_ulpi.sv */
`timescale 1ns/1ps

module usb_ulpi import ulpi_pkg::*; (
  input  logic         rst_n,
  input  logic         ulpi_clk,

  // ULPI PHY
  input  logic [7:0]   ulpi_data_i,
  input  logic         ulpi_dir_i,
  input  logic         ulpi_nxt_i,
  output logic [7:0]   ulpi_data_o,
  output logic         ulpi_stp_o,
  output logic         ulpi_reset_o,

  // TX stream, first beat carries the PID
  input  logic         tx_valid_i,
  input  stream_beat_t tx_beat_i,
  output logic         tx_ready_o,

  // RX stream
  output logic         rx_valid_o,
  output stream_beat_t rx_beat_o,
  input  logic         rx_ready_i,

  output logic         rx_overflow_o,
  output logic         usb_vbus_valid_o,
  output logic         usb_reset_o,
  output logic         usb_idle_o,
  output logic         usb_suspend_o
);

  bus_phase_t   phase;
  line_status_t status;
  logic         timer_clr;

  assign ulpi_reset_o     = rst_n;
  assign usb_vbus_valid_o = status.vbus_valid;

  ulpi_line_monitor u_line (
    .ulpi_clk    (ulpi_clk),
    .rst_n       (rst_n),
    .ulpi_data_i (ulpi_data_i),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .timer_clr_i (timer_clr),
    .phase_o     (phase),
    .status_o    (status)
  );

  ulpi_rx_path u_rx (
    .ulpi_clk      (ulpi_clk),
    .rst_n         (rst_n),
    .ulpi_data_i   (ulpi_data_i),
    .ulpi_dir_i    (ulpi_dir_i),
    .phase_i       (phase),
    .rx_ready_i    (rx_ready_i),
    .rx_valid_o    (rx_valid_o),
    .rx_beat_o     (rx_beat_o),
    .rx_overflow_o (rx_overflow_o)
  );

  ulpi_link_fsm u_fsm (
    .ulpi_clk      (ulpi_clk),
    .rst_n         (rst_n),
    .ulpi_dir_i    (ulpi_dir_i),
    .ulpi_nxt_i    (ulpi_nxt_i),
    .phase_i       (phase),
    .status_i      (status),
    .tx_valid_i    (tx_valid_i),
    .tx_beat_i     (tx_beat_i),
    .rx_ready_i    (rx_ready_i),
    .ulpi_data_o   (ulpi_data_o),
    .ulpi_stp_o    (ulpi_stp_o),
    .tx_ready_o    (tx_ready_o),
    .timer_clr_o   (timer_clr),
    .usb_reset_o   (usb_reset_o),
    .usb_idle_o    (usb_idle_o),
    .usb_suspend_o (usb_suspend_o)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic ulpi_clk_o,
  output logic rst_n_o
);

  initial begin
    ulpi_clk_o = 1'b0;
    rst_n_o    = 1'b0;
    repeat (3) @(posedge ulpi_clk_o);  // Reset held for 3 cycles
    #1;
    rst_n_o = 1'b1;
  end

  // 4 ns period
  always #2 ulpi_clk_o = ~ulpi_clk_o;

endmodule

/* tb_usb_ulpi.sv */
`timescale 1ns/1ps

module tb_usb_ulpi import ulpi_pkg::*; ();

  logic         ulpi_clk;
  logic         rst_n;
  logic [7:0]   phy_data;
  logic         phy_dir;
  logic         phy_nxt;
  logic [7:0]   link_data;
  logic         link_stp;
  logic         ulpi_reset;
  logic         tx_valid;
  stream_beat_t tx_beat;
  logic         tx_ready;
  logic         rx_valid;
  stream_beat_t rx_beat;
  logic         rx_ready;
  logic         rx_overflow;
  logic         vbus_valid;
  logic         usb_reset;
  logic         usb_idle;
  logic         usb_suspend;

  integer       seed = 32'hee6361c4;
  int           n_checks = 0;
  int           n_errors = 0;
  int           stp_count = 0;
  int           stall;
  logic         in_xfer = 1'b0;
  logic         phy_sending = 1'b0;  // PHY owns the bus for an RX sequence
  logic [7:0]   link_bytes[$];       // Bytes the PHY accepted with nxt
  logic [7:0]   rx_pkt[$];
  stream_beat_t rx_beats[$];

  tb_clk_gen u_clk_gen (
    .ulpi_clk_o (ulpi_clk),
    .rst_n_o    (rst_n)
  );

  usb_ulpi u_dut (
    .rst_n            (rst_n),
    .ulpi_clk         (ulpi_clk),
    .ulpi_data_i      (phy_data),
    .ulpi_dir_i       (phy_dir),
    .ulpi_nxt_i       (phy_nxt),
    .ulpi_data_o      (link_data),
    .ulpi_stp_o       (link_stp),
    .ulpi_reset_o     (ulpi_reset),
    .tx_valid_i       (tx_valid),
    .tx_beat_i        (tx_beat),
    .tx_ready_o       (tx_ready),
    .rx_valid_o       (rx_valid),
    .rx_beat_o        (rx_beat),
    .rx_ready_i       (rx_ready),
    .rx_overflow_o    (rx_overflow),
    .usb_vbus_valid_o (vbus_valid),
    .usb_reset_o      (usb_reset),
    .usb_idle_o       (usb_idle),
    .usb_suspend_o    (usb_suspend)
  );

  task automatic next_cycle();
    @(posedge ulpi_clk);
    #1;
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_beat(input string name, input stream_beat_t got,
                            input stream_beat_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s got %h/%b expected %h/%b", $time, name,
               got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic logic probe_level(input string name);
    if (name == "usb_idle_o") return usb_idle;
    else if (name == "usb_reset_o") return usb_reset;
    else return usb_suspend;
  endfunction

  task automatic wait_for_level(input string name, input logic level, input int max_cycles);
    int n;
    n = 0;
    while (probe_level(name) !== level && n < max_cycles) begin
      next_cycle();
      n++;
    end
    n_checks++;
    if (probe_level(name) !== level) begin
      n_errors++;
      $display("%s did not go to %b within %0d cycles at %0t ns", name, level, max_cycles, $time);
    end
  endtask

  function automatic rx_cmd_t make_rx_cmd(input logic [1:0] line, input logic [1:0] vbus,
                                          input logic [1:0] evt);
    rx_cmd_t c;
    c.alt_int    = 2'b00;
    c.rx_event   = evt;
    c.vbus_state = vbus;
    c.line_state = line;
    return c;
  endfunction

  // PHY side of link transfers: random stall, then nxt for each byte until stp
  always @(posedge ulpi_clk) begin
    #1;
    if (rst_n) begin
      if (link_stp) begin
        stp_count++;
        if (in_xfer) begin
          phy_nxt = 1'b0;
          in_xfer = 1'b0;
        end
      end else if (!phy_sending) begin
        if (!in_xfer && link_data != 8'h00) begin  // TX CMD on the bus
          in_xfer = 1'b1;
          stall   = {$random(seed)} % 3;
        end
        if (in_xfer) begin
          if (stall == 0) begin
            phy_nxt = 1'b1;
            link_bytes.push_back(link_data);
            stall = {$random(seed)} % 3;
          end else begin
            phy_nxt = 1'b0;
            stall--;
          end
        end
      end
    end
  end

  // RX stream monitor
  always @(posedge ulpi_clk) begin
    #1;
    if (rst_n && rx_valid) begin
      rx_beats.push_back(rx_beat);
    end
  end

  task automatic send_rx_cmd(input rx_cmd_t cmd);
    phy_sending = 1'b1;
    next_cycle();
    phy_dir = 1'b1;  // Turnaround
    phy_nxt = 1'b0;
    next_cycle();
    phy_data = cmd;
    next_cycle();
    phy_dir  = 1'b0;
    phy_data = 8'h00;
    next_cycle();
    phy_sending = 1'b0;
  endtask

  // Sends rx_pkt, closed by an RX CMD with RxActive low or by dir falling
  task automatic send_rx_packet(input logic end_by_cmd);
    phy_sending = 1'b1;
    next_cycle();
    phy_dir  = 1'b1;
    phy_nxt  = 1'b1;
    phy_data = 8'h00;
    foreach (rx_pkt[i]) begin
      next_cycle();
      phy_data = rx_pkt[i];
    end
    if (end_by_cmd) begin
      next_cycle();
      phy_nxt  = 1'b0;
      phy_data = make_rx_cmd(LINE_J, 2'b11, 2'b00);
    end
    next_cycle();
    phy_dir  = 1'b0;
    phy_nxt  = 1'b0;
    phy_data = 8'h00;
    next_cycle();
    phy_sending = 1'b0;
  endtask

  task automatic init_register_writes();
    int n;
    next_cycle();  // Still in reset
    check_byte("ulpi_data_o", link_data, 8'h00);
    check_bit("ulpi_stp_o", link_stp, 1'b0);
    check_bit("tx_ready_o", tx_ready, 1'b0);
    check_bit("rx_valid_o", rx_valid, 1'b0);
    check_bit("ulpi_reset_o", ulpi_reset, 1'b0);  // PHY held in reset with the link
    while (!rst_n) next_cycle();
    n = 0;
    while (stp_count < 2 && n < 200) begin
      next_cycle();
      n++;
    end
    repeat (2) next_cycle();
    check_bit("ulpi_reset_o", ulpi_reset, 1'b1);
    if (stp_count != 2 || link_bytes.size() != 4) begin
      n_errors++;
      $display("Register writes gave %0d stp and %0d bytes instead of 2 and 4",
               stp_count, link_bytes.size());
    end else begin
      check_byte("ulpi_data_o", link_bytes[0], REG_WRITE_OTG_CTRL);
      check_byte("ulpi_data_o", link_bytes[1], OTG_CTRL_INIT);
      check_byte("ulpi_data_o", link_bytes[2], REG_WRITE_FUNC_CTRL);
      check_byte("ulpi_data_o", link_bytes[3], FUNC_CTRL_FS);
    end
    send_rx_cmd(make_rx_cmd(LINE_J, 2'b11, 2'b00));
    repeat (SWITCH_TIME - 20) next_cycle();
    check_bit("usb_idle_o", usb_idle, 1'b0);  // Settle time not yet over
    wait_for_level("usb_idle_o", 1'b1, 60);
  endtask

  task automatic vbus_decode();
    send_rx_cmd(make_rx_cmd(LINE_J, 2'b10, 2'b00));  // Session valid only
    check_bit("usb_vbus_valid_o", vbus_valid, 1'b0);
    send_rx_cmd(make_rx_cmd(LINE_J, 2'b11, 2'b00));
    check_bit("usb_vbus_valid_o", vbus_valid, 1'b1);
  endtask

  task automatic transmit_packet();
    logic [7:0] bytes[4];
    logic       took;
    int         n;
    int         stp_before;
    bytes = '{8'hC3, 8'h11, 8'h22, 8'h33};  // DATA0 PID first
    link_bytes.delete();
    stp_before = stp_count;
    tx_valid = 1'b1;
    tx_beat  = '{data: bytes[0], last: 1'b0};
    next_cycle();
    check_byte("ulpi_data_o", link_data, {TX_CMD_PREFIX, bytes[0][3:0]});
    for (int i = 1; i < 4; i++) begin
      tx_beat = '{data: bytes[i], last: i == 3};
      n = 0;
      do begin
        took = tx_ready;
        next_cycle();
        n++;
      end while (!took && n < 50);
      if (!took) begin
        n_errors++;
        $display("TX beat %0d was never accepted", i);
      end
    end
    tx_valid = 1'b0;
    tx_beat  = '0;
    n = 0;
    while (stp_count == stp_before && n < 50) begin
      next_cycle();
      n++;
    end
    repeat (4) next_cycle();
    check_bit("ulpi_stp_o", stp_count == stp_before + 1, 1'b1);  // Exactly one stp
    if (link_bytes.size() != 4) begin
      n_errors++;
      $display("PHY accepted %0d TX bytes instead of 4", link_bytes.size());
    end else begin
      check_byte("ulpi_data_o", link_bytes[0], {TX_CMD_PREFIX, bytes[0][3:0]});
      for (int i = 1; i < 4; i++) check_byte("ulpi_data_o", link_bytes[i], bytes[i]);
    end
  endtask

  task automatic receive_packet();
    stream_beat_t exp;
    logic [7:0]   b;
    int           stp_before;
    rx_beats.delete();
    rx_pkt.delete();
    repeat (5) begin
      b = $random(seed);
      rx_pkt.push_back(b);
    end
    send_rx_packet(1'b1);
    repeat (3) next_cycle();
    if (rx_beats.size() != 5) begin
      n_errors++;
      $display("Got %0d RX beats instead of 5", rx_beats.size());
    end
    for (int i = 0; i < 5 && i < rx_beats.size(); i++) begin
      exp.data = rx_pkt[i];
      exp.last = i == 4;
      check_beat("rx_beat_o", rx_beats[i], exp);
    end
    check_bit("rx_overflow_o", rx_overflow, 1'b0);
    // Consumer stalled for a whole packet
    stp_before = stp_count;
    rx_ready = 1'b0;
    rx_pkt.delete();
    repeat (3) begin
      b = $random(seed);
      rx_pkt.push_back(b);
    end
    send_rx_packet(1'b0);
    repeat (2) next_cycle();
    rx_ready = 1'b1;
    check_bit("rx_overflow_o", rx_overflow, 1'b1);
    check_bit("ulpi_stp_o", stp_count != stp_before, 1'b1);
  endtask

  task automatic bus_reset_recovery();
    send_rx_cmd(make_rx_cmd(LINE_SE0, 2'b11, 2'b00));
    repeat (RESET_TIME - 20) next_cycle();
    check_bit("usb_reset_o", usb_reset, 1'b0);
    wait_for_level("usb_reset_o", 1'b1, 60);
    check_bit("usb_idle_o", usb_idle, 1'b0);
    send_rx_cmd(make_rx_cmd(LINE_J, 2'b11, 2'b00));
    wait_for_level("usb_reset_o", 1'b0, 20);
    check_bit("usb_idle_o", usb_idle, 1'b1);
  endtask

  task automatic suspend_resume();
    send_rx_cmd(make_rx_cmd(2'b10, 2'b11, 2'b00));  // K, then J restarts the timer
    send_rx_cmd(make_rx_cmd(LINE_J, 2'b11, 2'b00));
    repeat (SUSPEND_TIME - 20) next_cycle();
    check_bit("usb_suspend_o", usb_suspend, 1'b0);
    wait_for_level("usb_suspend_o", 1'b1, 60);
    send_rx_cmd(make_rx_cmd(2'b10, 2'b11, 2'b00));  // Resume signalling
    wait_for_level("usb_suspend_o", 1'b0, 20);
    check_bit("usb_idle_o", usb_idle, 1'b1);
  endtask

  initial begin
    phy_data = 8'h00;
    phy_dir  = 1'b0;
    phy_nxt  = 1'b0;
    tx_valid = 1'b0;
    tx_beat  = '0;
    rx_ready = 1'b1;
    init_register_writes();
    vbus_decode();
    transmit_packet();
    receive_packet();
    bus_reset_recovery();
    suspend_resume();
    repeat (5) next_cycle();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Long waits dominate, the rest fits in the margin
  initial begin : watchdog
    int limit;
    limit = SWITCH_TIME + RESET_TIME + SUSPEND_TIME + 5000;
    repeat (limit) @(posedge ulpi_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* all.f */
ulpi_pkg.sv
ulpi_line_monitor.sv
ulpi_rx_path.sv
ulpi_link_fsm.sv
usb_ulpi.sv
tb_clk_gen.sv
tb_usb_ulpi.sv

/* Bender.yml */
package:
  name: usb_ulpi

sources:
  - ulpi_pkg.sv
  - ulpi_line_monitor.sv
  - ulpi_rx_path.sv
  - ulpi_link_fsm.sv
  - usb_ulpi.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_usb_ulpi.sv
